//--- src.f
+incdir+include
rtl/array_bus_pkg.sv
rtl/array_ctrl_pkg.sv
rtl/fpga_ram.sv
rtl/ct_f_spsram_512x52.sv
rtl/array_init.sv
rtl/array_req_ctrl.sv
rtl/array_top.sv
sim/tb_array_top.sv

//--- run.sh
#!/bin/sh
# Builds the array testbench with Verilator and runs it
# Exit status is nonzero when the testbench stops on $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_array_top \
  -f src.f \
  -o tb_array_top

./obj_dir/tb_array_top

//--- sim/tb_array_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "array_config.svh"

// Testbench for the 512x52 array subsystem
module tb_array_top;

  localparam int WORD_W = `ARRAY_WORD_W;
  localparam int HALF_W = `ARRAY_HALF_W;
  localparam int ADDR_W = `ARRAY_ADDR_W;
  localparam int DEPTH = `ARRAY_DEPTH;

  localparam int CLK_HALF = 2;
  localparam int RESET_CYCLES = 5;
  localparam logic [31:0] LFSR_SEED = 32'hb3e2;

  // Operation counts per test
  localparam int N_CLEAR = 8;
  localparam int N_FULL = 16;
  localparam int N_HALF = 16;
  localparam int N_MIX = 400;
  localparam int N_RESET_READS = 8;

  // Cycles one handshake may take, gaps and back-pressure included
  localparam int OP_BOUND = 20;
  // A single ack may also wait behind a full init sweep
  localparam int ACK_BOUND = DEPTH + OP_BOUND;
  // One extra request is cut short by the second reset
  localparam int NUM_OPS = N_CLEAR + 2 * N_FULL + 2 * N_HALF + N_MIX + N_RESET_READS + 1;
  // Two sweeps, since reset is applied twice
  localparam int WATCHDOG_CYCLES = 2 * (DEPTH + RESET_CYCLES + 2) + NUM_OPS * OP_BOUND;

  logic                      CLK;
  logic                      arst_n;
  logic                      req;
  array_bus_pkg::array_req_t req_data;
  logic                      ack;
  array_bus_pkg::array_rsp_t rsp;

  // Reference copy of the array contents
  logic [WORD_W-1:0] model_mem [DEPTH];
  logic [31:0]       lfsr;
  // ack as seen at the previous falling edge
  logic              ack_seen;
  // Entries written by the full write test
  logic [ADDR_W-1:0] full_addrs [$];

  array_top dut0 (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .req     (req),
    .req_data(req_data),
    .ack     (ack),
    .rsp     (rsp)
  );

  always #CLK_HALF CLK = ~CLK;

  // x^32 + x^22 + x^2 + x + 1, shifting towards the MSB
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
                             input logic [WORD_W-1:0] actual);
    if (actual !== expected) begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      fail_run("response does not match the reference model");
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < DEPTH; i++) begin
      model_mem[i] = '0;
    end
  endtask

  // Async reset, ack must stay low throughout
  task automatic apply_reset();
    @(posedge CLK);
    arst_n <= 1'b0;
    req <= 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge CLK);
      check_value("reset ack", '0, WORD_W'(ack));
    end
    clear_model();
    @(posedge CLK);
    arst_n <= 1'b1;
  endtask

  // Idle cycles between requests, nothing may be acknowledged
  task automatic idle_gap(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      check_value("gap ack", '0, WORD_W'(ack));
    end
  endtask

  // Full four-phase handshake, response checked against the model
  task automatic run_request(input string name, input logic is_wr,
                             input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                             input logic [1:0] mask, input int hold_cycles);
    array_bus_pkg::array_req_t r;
    logic [WORD_W-1:0]         expected;
    int                        waited;
    r.op = is_wr ? array_bus_pkg::OP_WRITE : array_bus_pkg::OP_READ;
    r.addr = addr;
    r.wdata = wdata;
    r.half_mask = mask;
    // Model merge, one half per mask bit
    if (is_wr && mask[0]) begin
      model_mem[addr][HALF_W-1:0] = wdata[HALF_W-1:0];
    end
    if (is_wr && mask[1]) begin
      model_mem[addr][WORD_W-1:HALF_W] = wdata[WORD_W-1:HALF_W];
    end
    expected = model_mem[addr];
    @(posedge CLK);
    req <= 1'b1;
    req_data <= r;
    waited = 0;
    @(negedge CLK);
    while (!ack) begin
      waited++;
      if (waited > ACK_BOUND) begin
        fail_run($sformatf("%s: ack did not rise within %0d cycles", name, ACK_BOUND));
      end
      @(negedge CLK);
    end
    check_value(name, expected, rsp.rdata);
    // Back-pressure, ack and data must hold
    repeat (hold_cycles) begin
      @(negedge CLK);
      check_value({name, " ack held"}, WORD_W'(1), WORD_W'(ack));
      check_value({name, " rdata held"}, expected, rsp.rdata);
    end
    @(posedge CLK);
    req <= 1'b0;
    waited = 0;
    @(negedge CLK);
    while (ack) begin
      waited++;
      if (waited > OP_BOUND) begin
        fail_run($sformatf("%s: ack stayed high after req was dropped", name));
      end
      @(negedge CLK);
    end
  endtask

  // ack may only rise with req high
  always @(negedge CLK) begin
    if (ack && !ack_seen && !req) begin
      fail_run("ack rose while no request was pending");
    end
    ack_seen = ack;
  end

  // First request goes out while the sweep is still running
  task automatic clear_test();
    logic [63:0] v;
    for (int i = 0; i < N_CLEAR; i++) begin
      take_bits(ADDR_W, v);
      run_request($sformatf("clear read %0h", v[ADDR_W-1:0]), 1'b0, v[ADDR_W-1:0], '0,
                  2'b00, 0);
    end
  endtask

  task automatic full_write_test();
    logic [63:0] a;
    logic [63:0] d;
    for (int i = 0; i < N_FULL; i++) begin
      take_bits(ADDR_W, a);
      take_bits(WORD_W, d);
      full_addrs.push_back(a[ADDR_W-1:0]);
      run_request($sformatf("full write %0h", a[ADDR_W-1:0]), 1'b1, a[ADDR_W-1:0],
                  d[WORD_W-1:0], 2'b11, 0);
    end
    foreach (full_addrs[i]) begin
      run_request($sformatf("full read %0h", full_addrs[i]), 1'b0, full_addrs[i], '0,
                  2'b00, 0);
    end
  endtask

  // Only one half per write, the other must survive
  task automatic half_write_test();
    logic [ADDR_W-1:0] addrs [$];
    logic [63:0]       a;
    logic [63:0]       d;
    logic [63:0]       sel;
    for (int i = 0; i < N_HALF; i++) begin
      // Reuse full-write entries so the kept half is non-zero
      a = 64'(full_addrs[i % full_addrs.size()]);
      take_bits(WORD_W, d);
      take_bits(1, sel);
      addrs.push_back(a[ADDR_W-1:0]);
      run_request($sformatf("half write %0h", a[ADDR_W-1:0]), 1'b1, a[ADDR_W-1:0],
                  d[WORD_W-1:0], sel[0] ? 2'b10 : 2'b01, 0);
    end
    foreach (addrs[i]) begin
      run_request($sformatf("half read %0h", addrs[i]), 1'b0, addrs[i], '0, 2'b00, 0);
    end
  endtask

  // Narrow address range for frequent read-after-write hits
  task automatic mix_test();
    logic [63:0] op;
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] m;
    logic [63:0] hold;
    logic [63:0] gap;
    for (int i = 0; i < N_MIX; i++) begin
      take_bits(1, op);
      take_bits(6, a);
      take_bits(WORD_W, d);
      take_bits(2, m);
      take_bits(2, hold);
      take_bits(2, gap);
      idle_gap(int'(gap[1:0]));
      run_request($sformatf("mix op %0d", i), op[0], a[ADDR_W-1:0], d[WORD_W-1:0], m[1:0],
                  int'(hold[1:0]));
    end
  endtask

  // Reset hits while ack is high, then earlier entries must read back as zero
  task automatic reset_test();
    array_bus_pkg::array_req_t r;
    int                        waited;
    r = '0;
    r.op = array_bus_pkg::OP_READ;
    r.addr = full_addrs[0];
    @(posedge CLK);
    req <= 1'b1;
    req_data <= r;
    waited = 0;
    @(negedge CLK);
    while (!ack) begin
      waited++;
      if (waited > OP_BOUND) begin
        fail_run("ack did not rise for the request cut by reset");
      end
      @(negedge CLK);
    end
    check_value("reset cut read", model_mem[full_addrs[0]], rsp.rdata);
    // req stays high until reset drops it
    apply_reset();
    for (int i = 0; i < N_RESET_READS; i++) begin
      run_request($sformatf("reset read %0h", full_addrs[i]), 1'b0, full_addrs[i], '0,
                  2'b00, 0);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    fail_run($sformatf("Watchdog expired after %0d cycles, the DUT stopped answering",
                       WATCHDOG_CYCLES));
  end

  initial begin
    CLK = 1'b0;
    arst_n = 1'b0;
    req = 1'b0;
    req_data = '0;
    ack_seen = 1'b0;
    lfsr = LFSR_SEED;
    apply_reset();
    clear_test();
    full_write_test();
    half_write_test();
    mix_test();
    reset_test();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/array_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "array_config.svh"

// Array subsystem, initializer and controller around the 512x52 wrapper
module array_top (
  input  wire logic                      CLK,
  input  wire logic                      arst_n,
  input  wire logic                      req,
  input  wire array_bus_pkg::array_req_t req_data,
  output logic                           ack,
  output array_bus_pkg::array_rsp_t      rsp
);

  // Sweep port and its completion flag
  array_ctrl_pkg::sram_port_t init_port;
  logic                       init_done;

  // Controller to wrapper
  array_ctrl_pkg::sram_port_t sram;
  logic [`ARRAY_WORD_W-1:0]   q;

  array_init init0 (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .init_port(init_port),
    .init_done(init_done)
  );

  array_req_ctrl ctrl0 (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp),
    .init_port(init_port),
    .init_done(init_done),
    .sram     (sram),
    .q        (q)
  );

  // Struct fields onto the wrapper pins
  ct_f_spsram_512x52 sram0 (
    .CLK (CLK),
    .addr(sram.addr),
    .cen (sram.cen),
    .d   (sram.d),
    .gwen(sram.gwen),
    .wen (sram.wen),
    .q   (q)
  );

endmodule

`default_nettype wire

//--- rtl/array_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "array_config.svh"

// Owns the SRAM port, serves one client over four-phase req/ack
module array_req_ctrl (
  input  wire logic                       CLK,
  input  wire logic                       arst_n,
  // Client handshake
  input  wire logic                       req,
  input  wire array_bus_pkg::array_req_t  req_data,
  output logic                            ack,
  output array_bus_pkg::array_rsp_t       rsp,
  // Initializer
  input  wire array_ctrl_pkg::sram_port_t init_port,
  input  wire logic                       init_done,
  // Array
  output array_ctrl_pkg::sram_port_t      sram,
  input  wire logic [`ARRAY_WORD_W-1:0]   q
);

  array_ctrl_pkg::ctrl_state_e state;
  array_ctrl_pkg::ctrl_state_e state_nxt;

  // Set while serving a write
  logic is_write;

  // Request fields are stable while req is high, used as they come
  assign is_write = (req_data.op == array_bus_pkg::OP_WRITE);

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      array_ctrl_pkg::ST_INIT: begin
        // Client waits until the sweep is over
        if (init_done) begin
          state_nxt = array_ctrl_pkg::ST_IDLE;
        end
      end
      array_ctrl_pkg::ST_IDLE: begin
        if (req) begin
          state_nxt = array_ctrl_pkg::ST_ACCESS;
        end
      end
      array_ctrl_pkg::ST_ACCESS: begin
        // Write needs a second read to see the merged word
        state_nxt = is_write ? array_ctrl_pkg::ST_CAPTURE : array_ctrl_pkg::ST_ACK;
      end
      array_ctrl_pkg::ST_CAPTURE: begin
        state_nxt = array_ctrl_pkg::ST_ACK;
      end
      array_ctrl_pkg::ST_ACK: begin
        // Leave only once ack is up and the client let go
        if (ack && !req) begin
          state_nxt = array_ctrl_pkg::ST_IDLE;
        end
      end
      default: begin
        state_nxt = array_ctrl_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= array_ctrl_pkg::ST_INIT;
    end else begin
      state <= state_nxt;
    end
  end

  // Ack rises one cycle into ST_ACK, with rsp loaded on the same edge
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else if (state == array_ctrl_pkg::ST_ACK) begin
      if (!ack) begin
        ack <= 1'b1;
      end else if (!req) begin
        ack <= 1'b0;
      end
    end
  end

  // Wrapper holds its address, so q is still valid here
  always_ff @(posedge CLK) begin
    if (state == array_ctrl_pkg::ST_ACK && !ack) begin
      rsp.rdata <= q;
    end
  end

  // SRAM port mux
  always_comb begin
    // Idle array, chip deselected
    sram.cen  = 1'b1;
    sram.gwen = 1'b1;
    sram.wen  = '1;
    sram.addr = req_data.addr;
    sram.d    = req_data.wdata;
    case (state)
      array_ctrl_pkg::ST_INIT: begin
        sram = init_port;
      end
      array_ctrl_pkg::ST_ACCESS: begin
        sram.cen = 1'b0;
        if (is_write) begin
          sram.gwen = 1'b0;
          // Half mask to active-low half enables
          sram.wen[`ARRAY_HALF_W-1] = ~req_data.half_mask[0];
          sram.wen[`ARRAY_WORD_W-1] = ~req_data.half_mask[1];
        end
      end
      array_ctrl_pkg::ST_CAPTURE: begin
        // Read back the same entry
        sram.cen = 1'b0;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/array_init.sv
`timescale 1ns/1ps
`default_nettype none

`include "array_config.svh"

// Clears the whole array once after reset
module array_init (
  input  wire logic              CLK,
  input  wire logic              arst_n,
  output array_ctrl_pkg::sram_port_t init_port,
  output logic                   init_done
);

  // Final entry of the sweep
  localparam logic [`ARRAY_ADDR_W-1:0] LAST_ADDR = `ARRAY_ADDR_W'(`ARRAY_DEPTH - 1);

  // Sweep position
  logic [`ARRAY_ADDR_W-1:0] addr_cnt;
  // High during the write cycles
  logic                     busy;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      addr_cnt  <= '0;
      busy      <= 1'b0;
      init_done <= 1'b0;
    end else if (busy) begin
      addr_cnt <= addr_cnt + 1'b1;
      // Last write this cycle, done shows up next cycle
      if (addr_cnt == LAST_ADDR) begin
        busy      <= 1'b0;
        init_done <= 1'b1;
      end
    end else if (!init_done) begin
      // First edge out of reset kicks off the sweep
      busy <= 1'b1;
    end
  end

  // One full-word write of zero per busy cycle
  always_comb begin
    init_port.cen  = ~busy;
    init_port.gwen = ~busy;
    init_port.wen  = busy ? '0 : '1;
    init_port.addr = addr_cnt;
    init_port.d    = '0;
  end

endmodule

`default_nettype wire

//--- rtl/ct_f_spsram_512x52.sv
`timescale 1ns/1ps
`default_nettype none

`include "array_config.svh"

// 512x52 single port array, two 26-bit halves side by side
module ct_f_spsram_512x52 (
  input  wire logic                     CLK,
  input  wire logic [`ARRAY_ADDR_W-1:0] addr,
  input  wire logic                     cen,
  input  wire logic [`ARRAY_WORD_W-1:0] d,
  input  wire logic                     gwen,
  input  wire logic [`ARRAY_WORD_W-1:0] wen,
  output logic      [`ARRAY_WORD_W-1:0] q
);

  // Last address seen with the chip selected
  logic [`ARRAY_ADDR_W-1:0] addr_hold;
  // Address actually presented to both halves
  logic [`ARRAY_ADDR_W-1:0] ram_addr;

  // Capture only when selected
  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_hold <= addr;
    end
  end

  // Deselected array keeps reading the held entry
  // so q does not move while cen is high
  assign ram_addr = cen ? addr_hold : addr;

  // One RAM per half
  for (genvar h = 0; h < 2; h++) begin : g_half
    logic                     half_we;
    logic [`ARRAY_HALF_W-1:0] half_dout;

    // Top bit of each half's wen carries that half's enable
    assign half_we = !cen && !gwen && !wen[(h+1)*`ARRAY_HALF_W-1];

    fpga_ram #(
      .width(`ARRAY_HALF_W)
    ) ram (
      .CLK (CLK),
      .addr(ram_addr),
      .din (d[h*`ARRAY_HALF_W +: `ARRAY_HALF_W]),
      .we  (half_we),
      .dout(half_dout)
    );

    // Halves rejoin in the same order
    assign q[h*`ARRAY_HALF_W +: `ARRAY_HALF_W] = half_dout;
  end

endmodule

`default_nettype wire

//--- rtl/fpga_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "array_config.svh"

// Single port RAM, maps onto one block RAM
module fpga_ram #(
  parameter int width = `ARRAY_HALF_W
) (
  input  wire logic                     CLK,
  input  wire logic [`ARRAY_ADDR_W-1:0] addr,
  input  wire logic [width-1:0]         din,
  input  wire logic                     we,
  output logic      [width-1:0]         dout
);

  // Storage, no reset so the tools keep it in BRAM
  logic [width-1:0] mem [`ARRAY_DEPTH];

  // Write on the enabled edge
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
  end

  // Output register reads every cycle
  // Old data comes out on a write cycle (read-first)
  always_ff @(posedge CLK) begin
    dout <= mem[addr];
  end

endmodule

`default_nettype wire

//--- rtl/array_ctrl_pkg.sv
`default_nettype none

`include "array_config.svh"

// Array side of the controller, FSM states and SRAM pins
package array_ctrl_pkg;

  // Request controller states
  typedef enum logic [2:0] {
    ST_INIT    = 3'd0,
    ST_IDLE    = 3'd1,
    ST_ACCESS  = 3'd2,
    ST_CAPTURE = 3'd3,
    ST_ACK     = 3'd4
  } ctrl_state_e;

  // Wrapper pins, enables all active low
  typedef struct packed {
    logic                     cen;
    logic                     gwen;
    // Only bits HALF_W-1 and WORD_W-1 matter to the wrapper
    logic [`ARRAY_WORD_W-1:0] wen;
    logic [`ARRAY_ADDR_W-1:0] addr;
    logic [`ARRAY_WORD_W-1:0] d;
  } sram_port_t;

endpackage

`default_nettype wire

//--- rtl/array_bus_pkg.sv
`default_nettype none

`include "array_config.svh"

// Client side of the array, one requester over req/ack
package array_bus_pkg;

  // Command from the client
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } array_op_e;

  // Held stable by the client while req is high
  typedef struct packed {
    array_op_e                op;
    logic [`ARRAY_ADDR_W-1:0] addr;
    logic [`ARRAY_WORD_W-1:0] wdata;
    // Bit 0 low half, bit 1 high half, 1 writes that half
    logic [1:0]               half_mask;
  } array_req_t;

  // Valid while ack is high
  // For a write this is the word after the merge
  typedef struct packed {
    logic [`ARRAY_WORD_W-1:0] rdata;
  } array_rsp_t;

endpackage

`default_nettype wire

//--- include/array_config.svh
`ifndef ARRAY_CONFIG_SVH
`define ARRAY_CONFIG_SVH

// Array geometry, shared by packages and RTL

// Entry index width
`define ARRAY_ADDR_W 9

// One RAM half, matches the wrapper split
`define ARRAY_HALF_W 26

// Full word is always two halves
`define ARRAY_WORD_W (2 * `ARRAY_HALF_W)

// Entry count
`define ARRAY_DEPTH 512

`endif
